// ==== prefix_alu.f ====
prefix_alu_pkg.sv
prefix_adder.sv
add_sub_unit.sv
axil_reg_slave.sv
prefix_alu_top.sv
tb_prefix_alu.sv

// ==== Makefile ====
# Verilator build and run of the prefix ALU testbench

VERILATOR ?= verilator
SEED      ?= 10553
TIMEOUT   ?= 2000
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

TOP      := tb_prefix_alu
FILELIST := prefix_alu.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, write $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR=$(VERILATOR) SEED=$(SEED) TIMEOUT=$(TIMEOUT) LOG=$(LOG)"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-GSEED=$(SEED) -GTIMEOUT_CYCLES=$(TIMEOUT) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_prefix_alu.sv ====
`timescale 1ns/1ps
// Runs the ALU at DATA_WIDTH 8 only; the run stops after TIMEOUT_CYCLES clocks and SEED sets $random
module tb_prefix_alu #(
    parameter int SEED           = 32'h2939,
    parameter int TIMEOUT_CYCLES = 2000
);

    import prefix_alu_pkg::*;

    localparam int         DATA_WIDTH  = 8;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                        clk;
    logic                        rst;
    logic [AXI_ADDR_WIDTH-1:0]   awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [AXI_DATA_WIDTH-1:0]   wdata;
    logic [AXI_DATA_WIDTH/8-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;
    logic [AXI_ADDR_WIDTH-1:0]   araddr;
    logic                        arvalid;
    logic                        arready;
    logic [AXI_DATA_WIDTH-1:0]   rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;

    integer                seed;
    int                    mismatches;
    int                    failures;
    int                    cycles;
    logic [DATA_WIDTH-1:0] model_a;
    logic [DATA_WIDTH-1:0] model_b;
    logic [1:0]            model_op;

    prefix_alu_top #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #50 clk = ~clk;

    // Expected result word, subtract is A plus inverted B plus one
    function automatic logic [31:0] model_word(input logic [DATA_WIDTH-1:0] a,
                                               input logic [DATA_WIDTH-1:0] b,
                                               input logic [1:0]            code);
        logic [DATA_WIDTH:0] full;
        logic [31:0]         word;
        case (code)
            OP_ADD:  full = {1'b0, a} + {1'b0, b};
            OP_SUB:  full = {1'b0, a} + {1'b0, ~b} + {{DATA_WIDTH{1'b0}}, 1'b1};
            default: full = {1'b0, a};
        endcase
        word                   = '0;
        word[DATA_WIDTH-1:0]   = full[DATA_WIDTH-1:0];
        word[RESULT_CARRY_BIT] = full[DATA_WIDTH];
        word[RESULT_ZERO_BIT]  = (full[DATA_WIDTH-1:0] == '0);
        return word;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch %s expected %08h actual %08h", name, exp, act);
            mismatches++;
        end
    endtask

    // Stall holds bready low for that many cycles once bvalid is up
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall, output logic [1:0] resp);
        @(negedge clk);
        bready  = (stall == 0);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        for (int n = 0; n < stall; n++) begin
            @(negedge clk);
            assert (bvalid && bresp === resp) else begin
                $display("write response dropped or changed while bready was low");
                failures++;
            end
        end
        bready = 1'b1;
        @(negedge clk);
    endtask

    task automatic read_reg(input logic [3:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        @(negedge clk);
        rready  = (stall == 0);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        for (int n = 0; n < stall; n++) begin
            @(negedge clk);
            assert (rvalid && rdata === data) else begin
                $display("read response dropped or changed while rready was low");
                failures++;
            end
        end
        rready = 1'b1;
        @(negedge clk);
    endtask

    task automatic check_register(input string name, input logic [3:0] addr,
                                  input logic [31:0] exp, output logic [31:0] word);
        logic [1:0] resp;
        read_reg(addr, 0, word, resp);
        check_word(name, exp, word);
        check_word({name, " response"}, 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic set_operands(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [1:0] resp;
        write_reg(REG_A_OFFSET, 32'(a), 4'hF, 0, resp);
        check_word("write A response", 32'(RESP_OKAY), 32'(resp));
        write_reg(REG_B_OFFSET, 32'(b), 4'hF, 0, resp);
        check_word("write B response", 32'(RESP_OKAY), 32'(resp));
        model_a = a;
        model_b = b;
    endtask

    task automatic set_ctrl(input logic [1:0] code);
        logic [1:0] resp;
        write_reg(REG_CTRL_OFFSET, 32'(code), 4'hF, 0, resp);
        check_word("write ctrl response", 32'(RESP_OKAY), 32'(resp));
        model_op = code;
    endtask

    task automatic report_and_finish();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // Watchdog, about twice the cycles the full test sequence needs
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        failures++;
        report_and_finish();
    end

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic [1:0]  resp;
        clk        = 1'b0;
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        seed       = SEED;
        mismatches = 0;
        failures   = 0;
        model_a    = '0;
        model_b    = '0;
        model_op   = OP_PASS;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Reset values, result zero means the zero flag is set
        check_register("reset A", REG_A_OFFSET, 32'h0, word);
        check_register("reset B", REG_B_OFFSET, 32'h0, word);
        check_register("reset ctrl", REG_CTRL_OFFSET, 32'h0, word);
        check_register("reset result", REG_RESULT_OFFSET, model_word(0, 0, OP_PASS), word);

        // Pass, code 3 decodes the same way
        r = $random(seed);
        set_operands(r[DATA_WIDTH-1:0], r[2*DATA_WIDTH-1:DATA_WIDTH]);
        set_ctrl(OP_PASS);
        check_register("pass", REG_RESULT_OFFSET, model_word(model_a, model_b, model_op), word);
        set_ctrl(2'd3);
        check_register("pass code 3", REG_RESULT_OFFSET, model_word(model_a, model_b, 2'd3), word);

        set_ctrl(OP_ADD);
        for (int n = 0; n < 50; n++) begin
            r = $random(seed);
            set_operands(r[DATA_WIDTH-1:0], r[2*DATA_WIDTH-1:DATA_WIDTH]);
            check_register("add", REG_RESULT_OFFSET, model_word(model_a, model_b, model_op), word);
        end
        set_operands(8'hFF, 8'h01);
        check_register("add wrap", REG_RESULT_OFFSET, 32'h0003_0000, word);

        set_ctrl(OP_SUB);
        for (int n = 0; n < 51; n++) begin
            r = $random(seed);
            // Last pass uses equal operands
            if (n == 50) begin
                r[2*DATA_WIDTH-1:DATA_WIDTH] = r[DATA_WIDTH-1:0];
            end
            set_operands(r[DATA_WIDTH-1:0], r[2*DATA_WIDTH-1:DATA_WIDTH]);
            check_register("sub", REG_RESULT_OFFSET, model_word(model_a, model_b, model_op), word);
            check_word("sub no borrow", 32'(model_a >= model_b), 32'(word[RESULT_CARRY_BIT]));
            check_word("sub zero", 32'(model_a == model_b), 32'(word[RESULT_ZERO_BIT]));
        end

        // Result offset is read-only, empty strobe changes nothing
        r = $random(seed);
        write_reg(REG_RESULT_OFFSET, r, 4'hF, 0, resp);
        check_word("result write response", 32'(RESP_SLVERR), 32'(resp));
        check_register("result after write", REG_RESULT_OFFSET,
                       model_word(model_a, model_b, model_op), word);
        write_reg(REG_A_OFFSET, ~32'(model_a), 4'h0, 0, resp);
        check_word("empty strobe response", 32'(RESP_OKAY), 32'(resp));
        check_register("A after empty strobe", REG_A_OFFSET, 32'(model_a), word);

        // Back-pressure on both response channels
        r = $random(seed);
        model_a = r[DATA_WIDTH-1:0];
        write_reg(REG_A_OFFSET, 32'(model_a), 4'hF, 5, resp);
        check_word("stalled write response", 32'(RESP_OKAY), 32'(resp));
        read_reg(REG_RESULT_OFFSET, 5, word, resp);
        check_word("stalled read", model_word(model_a, model_b, model_op), word);
        check_register("read after stall", REG_RESULT_OFFSET,
                       model_word(model_a, model_b, model_op), word);

        report_and_finish();
    end

endmodule

// ==== prefix_alu_top.sv ====
`timescale 1ns/1ps
// AXI4-Lite prefix ALU; DATA_WIDTH from 2 to 16, result word trails register writes by one clock
module prefix_alu_top #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [prefix_alu_pkg::AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                                        awvalid,
    output logic                                        awready,
    input  logic [prefix_alu_pkg::AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [prefix_alu_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
    input  logic                                        wvalid,
    output logic                                        wready,
    output logic [1:0]                                  bresp,
    output logic                                        bvalid,
    input  logic                                        bready,
    input  logic [prefix_alu_pkg::AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                                        arvalid,
    output logic                                        arready,
    output logic [prefix_alu_pkg::AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                                  rresp,
    output logic                                        rvalid,
    input  logic                                        rready
);

    import prefix_alu_pkg::*;

    // Register contents toward the arithmetic unit
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    op_e                   op;

    // Registered arithmetic results back to the slave
    logic [DATA_WIDTH-1:0] result;
    logic                  carry;
    logic                  zero;

    axil_reg_slave #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_slave (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op        (op),
        .result    (result),
        .carry     (carry),
        .zero      (zero)
    );

    add_sub_unit #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_add_sub (
        .clk       (clk),
        .rst       (rst),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op        (op),
        .result    (result),
        .carry     (carry),
        .zero      (zero)
    );

endmodule

// ==== axil_reg_slave.sv ====
`timescale 1ns/1ps
// One write and one read in flight; AW and W are taken together and RESULT writes get SLVERR
module axil_reg_slave #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [prefix_alu_pkg::AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                                        awvalid,
    output logic                                        awready,
    input  logic [prefix_alu_pkg::AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [prefix_alu_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
    input  logic                                        wvalid,
    output logic                                        wready,
    output logic [1:0]                                  bresp,
    output logic                                        bvalid,
    input  logic                                        bready,
    input  logic [prefix_alu_pkg::AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                                        arvalid,
    output logic                                        arready,
    output logic [prefix_alu_pkg::AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                                  rresp,
    output logic                                        rvalid,
    input  logic                                        rready,
    output logic [DATA_WIDTH-1:0]                       operand_a,
    output logic [DATA_WIDTH-1:0]                       operand_b,
    output prefix_alu_pkg::op_e                         op,
    input  logic [DATA_WIDTH-1:0]                       result,
    input  logic                                        carry,
    input  logic                                        zero
);

    import prefix_alu_pkg::*;

    localparam int         STRB_WIDTH  = AXI_DATA_WIDTH / 8;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                      wr_ready;
    logic                      rd_ready;
    logic                      wr_fire;
    logic                      rd_fire;
    logic [AXI_ADDR_WIDTH-1:0] wr_offset;
    logic [AXI_ADDR_WIDTH-1:0] rd_offset;
    logic [AXI_DATA_WIDTH-1:0] word_a;
    logic [AXI_DATA_WIDTH-1:0] word_b;
    logic [AXI_DATA_WIDTH-1:0] word_ctrl;
    logic [AXI_DATA_WIDTH-1:0] word_result;
    logic [AXI_DATA_WIDTH-1:0] wr_cur;
    logic [AXI_DATA_WIDTH-1:0] wr_merged;
    logic [AXI_DATA_WIDTH-1:0] rd_word;

    // Replace only the bytes whose strobe is set
    function automatic logic [AXI_DATA_WIDTH-1:0] merge_bytes(
        input logic [AXI_DATA_WIDTH-1:0] cur,
        input logic [AXI_DATA_WIDTH-1:0] data,
        input logic [STRB_WIDTH-1:0]     strb
    );
        logic [AXI_DATA_WIDTH-1:0] merged;
        merged = cur;
        for (int j = 0; j < STRB_WIDTH; j++) begin
            if (strb[j]) begin
                merged[j*8 +: 8] = data[j*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign arready = rd_ready;
    assign rresp   = RESP_OKAY;

    assign wr_fire = awvalid && wvalid && wr_ready;
    assign rd_fire = arvalid && rd_ready;

    // Word-aligned decode, the two low address bits are ignored
    assign wr_offset = {awaddr[AXI_ADDR_WIDTH-1:2], 2'b00};
    assign rd_offset = {araddr[AXI_ADDR_WIDTH-1:2], 2'b00};

    // 32-bit views of the registers and of the result fields
    always_comb begin
        word_a                        = '0;
        word_a[DATA_WIDTH-1:0]        = operand_a;
        word_b                        = '0;
        word_b[DATA_WIDTH-1:0]        = operand_b;
        word_ctrl                     = '0;
        word_ctrl[1:0]                = op;
        word_result                   = '0;
        word_result[DATA_WIDTH-1:0]   = result;
        word_result[RESULT_CARRY_BIT] = carry;
        word_result[RESULT_ZERO_BIT]  = zero;
    end

    always_comb begin
        case (wr_offset)
            REG_A_OFFSET: wr_cur = word_a;
            REG_B_OFFSET: wr_cur = word_b;
            default:      wr_cur = word_ctrl;
        endcase
        wr_merged = merge_bytes(wr_cur, wdata, wstrb);
    end

    always_comb begin
        case (rd_offset)
            REG_A_OFFSET:    rd_word = word_a;
            REG_B_OFFSET:    rd_word = word_b;
            REG_CTRL_OFFSET: rd_word = word_ctrl;
            default:         rd_word = word_result;
        endcase
    end

    // Only implemented bits are kept, the rest of each word reads back as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            operand_a <= '0;
            operand_b <= '0;
            op        <= OP_PASS;
        end else if (wr_fire) begin
            case (wr_offset)
                REG_A_OFFSET:    operand_a <= wr_merged[DATA_WIDTH-1:0];
                REG_B_OFFSET:    operand_b <= wr_merged[DATA_WIDTH-1:0];
                REG_CTRL_OFFSET: op        <= op_e'(wr_merged[1:0]);
                default:         ;
            endcase
        end
    end

    // Write channel, ready drops for as long as the response is pending
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else if (wr_fire) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b1;
        end else if (bvalid) begin
            if (bready) begin
                bvalid   <= 1'b0;
                wr_ready <= 1'b1;
            end
        end else begin
            wr_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= (wr_offset == REG_RESULT_OFFSET) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Read channel, same scheme as the write side
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
        end else if (rd_fire) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b1;
        end else if (rvalid) begin
            if (rready) begin
                rvalid   <= 1'b0;
                rd_ready <= 1'b1;
            end
        end else begin
            rd_ready <= 1'b1;
        end
    end

    // Data captured at the address handshake and held through back-pressure
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    a_bvalid_holds: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response changed before it was accepted");

    a_rvalid_holds: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read response changed before it was accepted");

    a_no_aw_during_b: assert property (@(posedge clk) disable iff (rst)
        !(awready && bvalid))
        else $error("write address accepted while a response is pending");

endmodule

// ==== add_sub_unit.sv ====
`timescale 1ns/1ps
// Outputs lag the operands by one clock; any code other than add or subtract passes A with carry 0
module add_sub_unit #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] operand_a,
    input  logic [DATA_WIDTH-1:0] operand_b,
    input  prefix_alu_pkg::op_e   op,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  zero
);

    import prefix_alu_pkg::*;

    logic                  is_sub;
    logic                  is_arith;
    logic [DATA_WIDTH-1:0] adder_b;
    logic [DATA_WIDTH-1:0] adder_sum;
    logic                  adder_cout;
    logic [DATA_WIDTH-1:0] next_result;
    logic                  next_carry;

    // Subtract as A plus inverted B plus one
    assign is_sub   = (op == OP_SUB);
    assign is_arith = (op == OP_ADD) || is_sub;
    assign adder_b  = is_sub ? ~operand_b : operand_b;

    prefix_adder #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_adder (
        .a    (operand_a),
        .b    (adder_b),
        .cin  (is_sub),
        .sum  (adder_sum),
        .cout (adder_cout)
    );

    assign next_result = is_arith ? adder_sum : operand_a;
    assign next_carry  = is_arith & adder_cout;

    // Zero flag starts set since the result clears to zero
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            carry  <= 1'b0;
            zero   <= 1'b1;
        end else begin
            result <= next_result;
            carry  <= next_carry;
            zero   <= (next_result == '0);
        end
    end

    a_zero_matches_result: assert property (@(posedge clk) disable iff (rst)
        zero == (result == '0))
        else $error("zero flag disagrees with the registered result");

    a_pass_clears_carry: assert property (@(posedge clk) disable iff (rst)
        !is_arith |=> !carry)
        else $error("carry set one cycle after a pass operation");

endmodule

// ==== prefix_adder.sv ====
`timescale 1ns/1ps
// Purely combinational Brent-Kung adder; DATA_WIDTH must be 2 or more, no registers inside
module prefix_adder #(
    parameter int DATA_WIDTH = 8
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  logic                  cin,
    output logic [DATA_WIDTH-1:0] sum,
    output logic                  cout
);

    localparam int LEVELS = $clog2(DATA_WIDTH);

    // Group generate and propagate after each up-sweep level, level 0 is bitwise
    wire [DATA_WIDTH-1:0] g_lvl [LEVELS+1];
    wire [DATA_WIDTH-1:0] p_lvl [LEVELS+1];

    // c[0] is the carry-in, c[i] the carry into bit i
    wire [DATA_WIDTH:0] c;

    genvar i;
    genvar k;

    // Bitwise generate and propagate
    for (i = 0; i < DATA_WIDTH; i = i + 1) begin : g_bit
        assign g_lvl[0][i] = a[i] & b[i];
        assign p_lvl[0][i] = a[i] ^ b[i];
    end

    // Up-sweep levels of span 1, 2, 4 and so on
    // Node i absorbs the group ending at i-H when i+1 is a multiple of 2H
    for (k = 1; k <= LEVELS; k = k + 1) begin : g_level
        localparam int H = 1 << (k - 1);
        for (i = 0; i < DATA_WIDTH; i = i + 1) begin : g_node
            if ((i + 1) % (2 * H) == 0) begin : g_merge
                assign g_lvl[k][i] = g_lvl[k-1][i] | (p_lvl[k-1][i] & g_lvl[k-1][i-H]);
                assign p_lvl[k][i] = p_lvl[k-1][i] & p_lvl[k-1][i-H];
            end else begin : g_keep
                assign g_lvl[k][i] = g_lvl[k-1][i];
                assign p_lvl[k][i] = p_lvl[k-1][i];
            end
        end
    end

    assign c[0] = cin;

    // Fill every carry from the nearest prefix node below it
    // The final group at node i covers as many bits as the lowest set bit of i+1
    for (i = 0; i < DATA_WIDTH; i = i + 1) begin : g_carry
        localparam int SPAN = (i + 1) & ~i;
        assign c[i+1] = g_lvl[LEVELS][i] | (p_lvl[LEVELS][i] & c[i+1-SPAN]);
    end

    assign sum  = p_lvl[0] ^ c[DATA_WIDTH-1:0];
    assign cout = c[DATA_WIDTH];

endmodule

// ==== prefix_alu_pkg.sv ====
// Shared constants for the prefix ALU; result flag positions limit DATA_WIDTH to 16 or less
package prefix_alu_pkg;

    // AXI4-Lite port geometry
    localparam int AXI_ADDR_WIDTH = 4;
    localparam int AXI_DATA_WIDTH = 32;

    // Byte offsets of the register map
    localparam logic [3:0] REG_A_OFFSET      = 4'h0;
    localparam logic [3:0] REG_B_OFFSET      = 4'h4;
    localparam logic [3:0] REG_CTRL_OFFSET   = 4'h8;
    localparam logic [3:0] REG_RESULT_OFFSET = 4'hC;

    // Operation codes, code 3 decodes as pass
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2
    } op_e;

    // Flag positions in the result word, result itself sits in the low bits
    // Carry set during a subtract means no borrow
    localparam logic [4:0] RESULT_CARRY_BIT = 5'd16;
    localparam logic [4:0] RESULT_ZERO_BIT  = 5'd17;

endpackage
